//--- sim.f
src/prof_reason_pkg.sv
src/prof_count_pkg.sv
src/prof_fe_stage.sv
src/prof_isd_stage.sv
src/prof_ex_stage.sv
src/prof_stall_classifier.sv
src/prof_stall_histogram.sv
src/stall_profiler_top.sv
sim/tb_clock_gen.sv
sim/stall_profiler_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the stall profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=stall_profiler_sim

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module stall_profiler_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- sim/stall_profiler_tb.sv
`default_nettype none

module stall_profiler_tb
  import prof_reason_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CNT_WIDTH     = 16;
  localparam int unsigned NUM_EX_STAGES = 2;
  localparam int unsigned DEPTH         = 3 + NUM_EX_STAGES;
  localparam int unsigned POLL_LIMIT    = 40;
  localparam int unsigned RETIRE_RUN    = 7;
  localparam int unsigned RANDOM_PULSES = 16;
  localparam logic [31:0] SEED          = 32'h8a73ad78;

  typedef logic [CNT_WIDTH-1:0] cnt_t;

  logic       clk;
  logic       rst_n;
  logic       freeze;
  logic       fe_cmd;
  logic       icache_data_v;
  logic       br_ovr;
  logic       mispredict;
  logic       data_haz;
  logic       load_dep;
  logic       mul_dep;
  logic       struct_haz;
  logic       exception;
  logic       interrupt;
  logic       dcache_miss;
  logic       instret;
  logic       clear;
  logic [3:0] rd_addr;
  cnt_t       rd_data;
  cnt_t       instret_cnt;

  cnt_t        exp_bins [NUM_REASONS];

  tb_clock_gen #(
    .PERIOD_NS    (10),
    .RESET_CYCLES (5)
  ) clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  stall_profiler_top dut0 (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .freeze_i        (freeze),
    .fe_cmd_i        (fe_cmd),
    .icache_data_v_i (icache_data_v),
    .br_ovr_i        (br_ovr),
    .mispredict_i    (mispredict),
    .data_haz_i      (data_haz),
    .load_dep_i      (load_dep),
    .mul_dep_i       (mul_dep),
    .struct_haz_i    (struct_haz),
    .exception_i     (exception),
    .interrupt_i     (interrupt),
    .dcache_miss_i   (dcache_miss),
    .instret_i       (instret),
    .clear_i         (clear),
    .rd_addr_i       (rd_addr),
    .rd_data_o       (rd_data),
    .instret_cnt_o   (instret_cnt)
  );

  task automatic end_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input cnt_t actual, input cnt_t expected, input string what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
               $time, what, actual, expected);
      end_with_failure();
    end
  endtask

  // Polls on half-ns steps that never meet a clock edge
  task automatic tick();
    int unsigned polls;
    polls = 0;
    #0.5;
    while (clk !== 1'b0 && polls < POLL_LIMIT)
    begin
      #1;
      polls++;
    end
    while (clk !== 1'b1 && polls < POLL_LIMIT)
    begin
      #1;
      polls++;
    end
    if (polls >= POLL_LIMIT)
    begin
      $display("Timeout: the clock stopped toggling at %0t", $time);
      end_with_failure();
    end
    // Inputs change 1 ns after the rising edge
    #0.5;
  endtask

  task automatic wait_cycles(input int unsigned n);
    for (int unsigned i = 0; i < n; i++)
    begin
      tick();
    end
  endtask

  task automatic set_event(input stall_code_e code, input logic value);
    case (code)
      e_fe_cmd:          fe_cmd = value;
      e_icache_miss:     icache_data_v = ~value;
      e_branch_override: br_ovr = value;
      e_mispredict:      mispredict = value;
      e_data_haz:        data_haz = value;
      e_load_dep:        load_dep = value;
      e_mul_dep:         mul_dep = value;
      e_struct_haz:      struct_haz = value;
      e_exception:       exception = value;
      e_interrupt:       interrupt = value;
      e_dcache_miss:     dcache_miss = value;
      default:           ;
    endcase
  endtask

  // Number of stage registers that OR in each event
  function automatic int unsigned stage_count(input stall_code_e code);
    case (code)
      e_fe_cmd:                     return 3;
      e_icache_miss, e_mispredict:  return 2;
      e_dcache_miss, e_interrupt,
      e_exception:                  return NUM_EX_STAGES;
      e_unknown:                    return 0;
      default:                      return 1;
    endcase
  endfunction

  task automatic zero_expected();
    for (int unsigned i = 0; i < NUM_REASONS; i++)
    begin
      exp_bins[i] = '0;
    end
  endtask

  task automatic clear_counters();
    clear = 1'b1;
    tick();
    clear = 1'b0;
  endtask

  task automatic start_test();
    instret = 1'b1;
    wait_cycles(DEPTH);
    clear_counters();
    zero_expected();
  endtask

  // One-cycle event followed by enough quiet cycles for every copy to reach the classifier
  task automatic pulse_event(input stall_code_e code, input logic counted);
    int unsigned hits;
    instret = 1'b0;
    set_event(code, 1'b1);
    tick();
    set_event(code, 1'b0);
    wait_cycles(DEPTH);
    if (counted)
    begin
      hits = stage_count(code);
      exp_bins[code] = exp_bins[code] + cnt_t'(hits);
      // Remaining low-instret cycles see an empty vector
      exp_bins[e_unknown] = exp_bins[e_unknown] + cnt_t'(DEPTH + 1 - hits);
    end
  endtask

  task automatic drain();
    instret = 1'b1;
    wait_cycles(DEPTH);
  endtask

  task automatic read_bin(input logic [3:0] addr, output cnt_t data);
    rd_addr = addr;
    tick();
    data = rd_data;
  endtask

  task automatic check_bins(input string test_name);
    cnt_t got;
    cnt_t want;
    for (int unsigned a = 0; a < 16; a++)
    begin
      read_bin(4'(a), got);
      want = (a < NUM_REASONS) ? exp_bins[a] : '0;
      check_value(got, want, $sformatf("%s bin %0d", test_name, a));
    end
  endtask

  task automatic test_reset_clear();
    start_test();
    check_value(instret_cnt, '0, "reset instret count");
    drain();
    check_bins("reset");
  endtask

  task automatic test_stage_counts();
    start_test();
    for (int unsigned c = 1; c < NUM_REASONS; c++)
    begin
      pulse_event(stall_code_e'(4'(c)), 1'b1);
    end
    drain();
    check_bins("stage counts");
  endtask

  task automatic test_priority();
    start_test();
    instret = 1'b0;
    data_haz = 1'b1;
    load_dep = 1'b1;
    tick();
    data_haz = 1'b0;
    load_dep = 1'b0;
    wait_cycles(DEPTH);
    // Both land in ISD together and the lower code wins
    exp_bins[e_load_dep] = cnt_t'(1);
    exp_bins[e_unknown]  = cnt_t'(DEPTH);
    drain();
    check_bins("priority");
  endtask

  task automatic test_retire_unknown();
    start_test();
    wait_cycles(RETIRE_RUN);
    check_value(instret_cnt, cnt_t'(RETIRE_RUN), "retire run");
    instret = 1'b0;
    wait_cycles(RETIRE_RUN);
    exp_bins[e_unknown] = cnt_t'(RETIRE_RUN);
    drain();
    check_value(instret_cnt, cnt_t'(RETIRE_RUN + DEPTH), "retire after drain");
    check_bins("retire");
  endtask

  task automatic test_freeze();
    start_test();
    freeze = 1'b1;
    wait_cycles(DEPTH);
    pulse_event(e_fe_cmd, 1'b0);
    pulse_event(e_data_haz, 1'b0);
    pulse_event(e_icache_miss, 1'b0);
    pulse_event(e_dcache_miss, 1'b0);
    freeze = 1'b0;
    drain();
    // Only the cycles before the freeze reached the classifier
    check_value(instret_cnt, cnt_t'(DEPTH), "retire under freeze");
    check_bins("freeze");
  endtask

  task automatic test_random_then_clear();
    stall_code_e code;
    start_test();
    for (int unsigned n = 0; n < RANDOM_PULSES; n++)
    begin
      code = stall_code_e'(4'($urandom_range(NUM_REASONS - 1, 1)));
      pulse_event(code, 1'b1);
    end
    drain();
    check_bins("random");
    clear_counters();
    zero_expected();
    check_value(instret_cnt, '0, "instret after clear");
    check_bins("after clear");
  endtask

  initial
  begin
    int unsigned guard;
    $timeformat(-9, 1, " ns", 0);
    freeze        = 1'b0;
    fe_cmd        = 1'b0;
    icache_data_v = 1'b1;
    br_ovr        = 1'b0;
    mispredict    = 1'b0;
    data_haz      = 1'b0;
    load_dep      = 1'b0;
    mul_dep       = 1'b0;
    struct_haz    = 1'b0;
    exception     = 1'b0;
    interrupt     = 1'b0;
    dcache_miss   = 1'b0;
    instret       = 1'b1;
    clear         = 1'b0;
    rd_addr       = '0;
    void'($urandom(SEED));

    guard = 0;
    while (rst_n !== 1'b1 && guard < 20)
    begin
      tick();
      guard++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("Timeout: reset was never released");
      end_with_failure();
    end

    test_reset_clear();
    test_stage_counts();
    test_priority();
    test_retire_unknown();
    test_freeze();
    test_random_then_clear();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 5
)
(
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- src/stall_profiler_top.sv
`default_nettype none

module stall_profiler_top
  import prof_reason_pkg::*;
  import prof_count_pkg::*;
#(
  parameter int unsigned CNT_WIDTH     = CNT_WIDTH_DEFAULT,
  parameter int unsigned NUM_EX_STAGES = 2
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 freeze_i,
  // Front end
  input  logic                 fe_cmd_i,
  input  logic                 icache_data_v_i,
  input  logic                 br_ovr_i,
  input  logic                 mispredict_i,
  // Issue
  input  logic                 data_haz_i,
  input  logic                 load_dep_i,
  input  logic                 mul_dep_i,
  input  logic                 struct_haz_i,
  // Back end
  input  logic                 exception_i,
  input  logic                 interrupt_i,
  input  logic                 dcache_miss_i,
  // Commit and control
  input  logic                 instret_i,
  input  logic                 clear_i,
  input  logic [3:0]           rd_addr_i,
  output logic [CNT_WIDTH-1:0] rd_data_o,
  output logic [CNT_WIDTH-1:0] instret_cnt_o
);

  stall_vec_t  fe_reasons;
  stall_vec_t  isd_reasons;
  stall_vec_t  ex_reasons;
  logic        fe_frozen;
  logic        isd_frozen;
  logic        ex_frozen;
  logic        stall_v;
  logic        retire_v;
  stall_code_e stall_code;

  prof_fe_stage u_fe (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .freeze_i        (freeze_i),
    .fe_cmd_i        (fe_cmd_i),
    .icache_data_v_i (icache_data_v_i),
    .br_ovr_i        (br_ovr_i),
    .mispredict_i    (mispredict_i),
    .reasons_o       (fe_reasons),
    .frozen_o        (fe_frozen)
  );

  prof_isd_stage u_isd (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reasons_i       (fe_reasons),
    .frozen_i        (fe_frozen),
    .fe_cmd_i        (fe_cmd_i),
    .icache_data_v_i (icache_data_v_i),
    .mispredict_i    (mispredict_i),
    .data_haz_i      (data_haz_i),
    .load_dep_i      (load_dep_i),
    .mul_dep_i       (mul_dep_i),
    .struct_haz_i    (struct_haz_i),
    .reasons_o       (isd_reasons),
    .frozen_o        (isd_frozen)
  );

  prof_ex_stage #(
    .NUM_EX_STAGES (NUM_EX_STAGES)
  ) u_ex (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reasons_i     (isd_reasons),
    .frozen_i      (isd_frozen),
    .exception_i   (exception_i),
    .interrupt_i   (interrupt_i),
    .dcache_miss_i (dcache_miss_i),
    .reasons_o     (ex_reasons),
    .frozen_o      (ex_frozen)
  );

  // Last EX register lines up with this cycle's instret
  prof_stall_classifier u_classify (
    .reasons_i    (ex_reasons),
    .frozen_i     (ex_frozen),
    .instret_i    (instret_i),
    .stall_v_o    (stall_v),
    .stall_code_o (stall_code),
    .retire_v_o   (retire_v)
  );

  prof_stall_histogram #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_hist (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stall_v_i     (stall_v),
    .stall_code_i  (stall_code),
    .retire_v_i    (retire_v),
    .clear_i       (clear_i),
    .rd_addr_i     (rd_addr_i),
    .rd_data_o     (rd_data_o),
    .instret_cnt_o (instret_cnt_o)
  );

endmodule

`default_nettype wire

//--- src/prof_stall_histogram.sv
`default_nettype none

module prof_stall_histogram
  import prof_reason_pkg::*;
  import prof_count_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = CNT_WIDTH_DEFAULT
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 stall_v_i,
  input  stall_code_e          stall_code_i,
  input  logic                 retire_v_i,
  input  logic                 clear_i,
  input  logic [3:0]           rd_addr_i,
  output logic [CNT_WIDTH-1:0] rd_data_o,
  output logic [CNT_WIDTH-1:0] instret_cnt_o
);

  typedef logic [CNT_WIDTH-1:0] cnt_t;

  localparam cnt_t CNT_SAT = cnt_t'(sat_limit(CNT_WIDTH));

  cnt_t bins_q [NUM_REASONS];
  cnt_t retire_q;
  cnt_t rd_data_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < NUM_REASONS; i++)
      begin
        bins_q[i] <= '0;
      end
      retire_q <= '0;
    end
    else if (clear_i)
    begin
      for (int i = 0; i < NUM_REASONS; i++)
      begin
        bins_q[i] <= '0;
      end
      retire_q <= '0;
    end
    else
    begin
      // Counters stick at all ones
      if (stall_v_i && (int'(stall_code_i) < NUM_REASONS) && (bins_q[stall_code_i] != CNT_SAT))
      begin
        bins_q[stall_code_i] <= bins_q[stall_code_i] + cnt_t'(1);
      end
      if (retire_v_i && (retire_q != CNT_SAT))
      begin
        retire_q <= retire_q + cnt_t'(1);
      end
    end
  end

  // Registered read, unused addresses return zero
  always_ff @(posedge clk_i)
  begin
    rd_data_q <= (int'(rd_addr_i) < NUM_REASONS) ? bins_q[rd_addr_i] : '0;
  end

  assign rd_data_o     = rd_data_q;
  assign instret_cnt_o = retire_q;

  a_stall_xor_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(stall_v_i && retire_v_i));

endmodule

`default_nettype wire

//--- src/prof_stall_classifier.sv
`default_nettype none

module prof_stall_classifier
  import prof_reason_pkg::*;
(
  input  stall_vec_t  reasons_i,
  input  logic        frozen_i,
  input  logic        instret_i,
  output logic        stall_v_o,
  output stall_code_e stall_code_o,
  output logic        retire_v_o
);

  stall_code_e code;

  // Scan from the top down so the lowest set bit wins
  always_comb
  begin
    code = e_unknown;
    for (int i = NUM_REASONS - 1; i >= 1; i--)
    begin
      if (reasons_i[i])
      begin
        code = stall_code_e'(i);
      end
    end
    // A chosen code must be one of the set bits
    if (code != e_unknown)
    begin
      a_code_matches: assert (reasons_i[code]);
    end
  end

  assign stall_code_o = code;
  assign stall_v_o    = ~frozen_i & ~instret_i;
  assign retire_v_o   = ~frozen_i & instret_i;

endmodule

`default_nettype wire

//--- src/prof_ex_stage.sv
`default_nettype none

module prof_ex_stage
  import prof_reason_pkg::*;
#(
  parameter int unsigned NUM_EX_STAGES = 2
)
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  stall_vec_t reasons_i,
  input  logic       frozen_i,
  input  logic       exception_i,
  input  logic       interrupt_i,
  input  logic       dcache_miss_i,
  output stall_vec_t reasons_o,
  output logic       frozen_o
);

  stall_vec_t be_vec;
  stall_vec_t stage_q [NUM_EX_STAGES];
  logic       frozen_q [NUM_EX_STAGES];

  // Back-end events, the same for every EX register
  always_comb
  begin
    be_vec                = '0;
    be_vec[e_exception]   = exception_i;
    be_vec[e_interrupt]   = interrupt_i;
    be_vec[e_dcache_miss] = dcache_miss_i;
  end

  for (genvar i = 0; i < NUM_EX_STAGES; i++)
  begin : g_stage
    stall_vec_t stage_in;
    logic       frozen_in;

    if (i == 0)
    begin : g_head
      assign stage_in  = reasons_i;
      assign frozen_in = frozen_i;
    end
    else
    begin : g_body
      assign stage_in  = stage_q[i-1];
      assign frozen_in = frozen_q[i-1];
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
      begin
        stage_q[i]  <= '0;
        frozen_q[i] <= 1'b1;
      end
      else
      begin
        stage_q[i]  <= stage_in | be_vec;
        frozen_q[i] <= frozen_in;
      end
    end
  end

  assign reasons_o = stage_q[NUM_EX_STAGES-1];
  assign frozen_o  = frozen_q[NUM_EX_STAGES-1];

  a_ex_depth: assert property (@(posedge clk_i)
    NUM_EX_STAGES >= 1 && NUM_EX_STAGES <= 4);

endmodule

`default_nettype wire

//--- src/prof_isd_stage.sv
`default_nettype none

module prof_isd_stage
  import prof_reason_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  stall_vec_t reasons_i,
  input  logic       frozen_i,
  input  logic       fe_cmd_i,
  input  logic       icache_data_v_i,
  input  logic       mispredict_i,
  input  logic       data_haz_i,
  input  logic       load_dep_i,
  input  logic       mul_dep_i,
  input  logic       struct_haz_i,
  output stall_vec_t reasons_o,
  output logic       frozen_o
);

  stall_vec_t isd_d;

  always_comb
  begin
    isd_d                  = reasons_i;
    // Front-end conditions that still leave issue empty
    isd_d[e_fe_cmd]       |= fe_cmd_i;
    isd_d[e_icache_miss]  |= ~icache_data_v_i;
    isd_d[e_mispredict]   |= mispredict_i;
    // Dispatch hazards
    isd_d[e_data_haz]     |= data_haz_i;
    isd_d[e_load_dep]     |= load_dep_i;
    isd_d[e_mul_dep]      |= mul_dep_i;
    isd_d[e_struct_haz]   |= struct_haz_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      reasons_o <= '0;
      frozen_o  <= 1'b1;
    end
    else
    begin
      reasons_o <= isd_d;
      frozen_o  <= frozen_i;
    end
  end

endmodule

`default_nettype wire

//--- src/prof_fe_stage.sv
`default_nettype none

module prof_fe_stage
  import prof_reason_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       freeze_i,
  input  logic       fe_cmd_i,
  input  logic       icache_data_v_i,
  input  logic       br_ovr_i,
  input  logic       mispredict_i,
  output stall_vec_t reasons_o,
  output logic       frozen_o
);

  stall_vec_t if1_d;
  stall_vec_t if1_q;
  stall_vec_t if2_d;
  stall_vec_t if2_q;
  logic       if1_frozen_q;
  logic       if2_frozen_q;

  always_comb
  begin
    // IF1 starts the cycle's vector from nothing
    if1_d                      = '0;
    if1_d[e_fe_cmd]            = fe_cmd_i;
    if1_d[e_branch_override]   = br_ovr_i;

    if2_d                      = if1_q;
    if2_d[e_fe_cmd]           |= fe_cmd_i;
    // No fetch data means the icache missed
    if2_d[e_icache_miss]      |= ~icache_data_v_i;
    if2_d[e_mispredict]       |= mispredict_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      if1_q        <= '0;
      if2_q        <= '0;
      if1_frozen_q <= 1'b1;
      if2_frozen_q <= 1'b1;
    end
    else
    begin
      if1_q        <= if1_d;
      if2_q        <= if2_d;
      if1_frozen_q <= freeze_i;
      if2_frozen_q <= if1_frozen_q;
    end
  end

  assign reasons_o = if2_q;
  assign frozen_o  = if2_frozen_q;

  a_fe_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({reasons_o, frozen_o}));

endmodule

`default_nettype wire

//--- src/prof_count_pkg.sv
`default_nettype none

package prof_count_pkg;

  localparam int unsigned CNT_WIDTH_DEFAULT = 16;
  localparam int unsigned CNT_WIDTH_MAX     = 32;

  // All-ones value of a counter of the given width
  function automatic logic [CNT_WIDTH_MAX-1:0] sat_limit(input int unsigned width);
    logic [63:0] lim;
    lim = (64'd1 << width) - 64'd1;
    return lim[CNT_WIDTH_MAX-1:0];
  endfunction

endpackage

`default_nettype wire

//--- src/prof_reason_pkg.sv
`default_nettype none

package prof_reason_pkg;

  localparam int unsigned NUM_REASONS = 12;

  // One bit per reason, bit index equals reason code
  typedef logic [NUM_REASONS-1:0] stall_vec_t;

  // Lower code wins when several reasons are present
  typedef enum logic [3:0]
  {
    e_unknown         = 4'd0,
    e_dcache_miss     = 4'd1,
    e_interrupt       = 4'd2,
    e_exception       = 4'd3,
    e_struct_haz      = 4'd4,
    e_mul_dep         = 4'd5,
    e_load_dep        = 4'd6,
    e_data_haz        = 4'd7,
    e_mispredict      = 4'd8,
    e_branch_override = 4'd9,
    e_icache_miss     = 4'd10,
    e_fe_cmd          = 4'd11
  } stall_code_e;

  // Bit e_unknown is never set in a vector; an empty vector classifies as unknown

endpackage

`default_nettype wire
